// File: hw/ht_pkg.sv
package ht_pkg;

	// ======================================================================
	// Sizes
	// ======================================================================
	localparam int NUM_SYM = 8;
	// Leaves plus one merged node per step
	localparam int NUM_NODE = 2 * NUM_SYM - 1;
	localparam int IN_W_WIDTH = 3;
	// Wide enough for the full sum of eight weights of seven
	localparam int W_WIDTH = 6;
	// Longest path in a tree of eight leaves
	localparam int MAX_LEN = NUM_SYM - 1;
	localparam int NUM_OUT = 5;

	// ======================================================================
	// Types
	// ======================================================================
	typedef logic [$clog2(NUM_NODE + 1)-1:0] node_id_t;
	typedef logic [W_WIDTH-1:0] weight_t;
	typedef logic [$clog2(NUM_SYM)-1:0] sym_t;
	typedef logic [$clog2(MAX_LEN + 1)-1:0] len_t;
	// Bit 0 is the root side bit
	typedef logic [MAX_LEN-1:0] code_t;

	// Empty slot in the node list, sorts behind every live node
	localparam node_id_t NODE_EMPTY = '1;
	localparam weight_t WEIGHT_EMPTY = '1;

	// ======================================================================
	// Output symbol sequences
	// ======================================================================
	localparam sym_t OUT_SEQ_0 [NUM_OUT] = '{
		sym_t'(3), sym_t'(2), sym_t'(1), sym_t'(0), sym_t'(4)
	};
	localparam sym_t OUT_SEQ_1 [NUM_OUT] = '{
		sym_t'(3), sym_t'(5), sym_t'(2), sym_t'(7), sym_t'(6)
	};

endpackage

// File: hw/ht_merge_if.sv
`timescale 1ns/100ps

interface merge_if import ht_pkg::*; ();

	// One merge step, valid while step is high
	logic step;
	node_id_t small_node;
	node_id_t big_node;
	// Id given to the node built from small and big
	node_id_t new_node;

	modport ctrl (
		output step,
		output small_node,
		output big_node,
		output new_node
	);

	modport lane (
		input step,
		input small_node,
		input big_node,
		input new_node
	);

endinterface

// File: hw/ht_node_sorter.sv
`timescale 1ns/100ps

module ht_node_sorter import ht_pkg::*; #(
	parameter int NUM_SYM_P = NUM_SYM
) (
	input  node_id_t in_id  [NUM_SYM_P],
	input  weight_t  in_w   [NUM_SYM_P],
	output node_id_t out_id [NUM_SYM_P],
	output weight_t  out_w  [NUM_SYM_P]
);

	// Order by weight, lower id wins a tie
	function automatic logic goes_after(
		input weight_t  wa,
		input node_id_t ida,
		input weight_t  wb,
		input node_id_t idb
	);
		return (wa > wb) || ((wa == wb) && (ida > idb));
	endfunction

	// ======================================================================
	// Odd-even transposition network
	// ======================================================================
	always_comb begin
		node_id_t id_v [NUM_SYM_P];
		weight_t  w_v  [NUM_SYM_P];
		node_id_t id_tmp;
		weight_t  w_tmp;

		id_v = in_id;
		w_v = in_w;
		id_tmp = '0;
		w_tmp = '0;

		// N stages are enough for N entries
		for (int s = 0; s < NUM_SYM_P; s++) begin
			// Even stages pair 0-1, 2-3, odd stages pair 1-2, 3-4
			for (int i = s % 2; i + 1 < NUM_SYM_P; i += 2) begin
				if (goes_after(w_v[i], id_v[i], w_v[i+1], id_v[i+1])) begin
					id_tmp = id_v[i];
					w_tmp = w_v[i];
					id_v[i] = id_v[i+1];
					w_v[i] = w_v[i+1];
					id_v[i+1] = id_tmp;
					w_v[i+1] = w_tmp;
				end
			end
		end

		out_id = id_v;
		out_w = w_v;
	end

endmodule

// File: hw/ht_merge_ctrl.sv
`timescale 1ns/100ps

module ht_merge_ctrl import ht_pkg::*; #(
	parameter int NUM_SYM_P = NUM_SYM
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic [IN_W_WIDTH-1:0] in_weight,
	input  logic                  out_mode,
	merge_if.ctrl                 mrg,
	output logic                  clear,
	output logic                  done,
	output logic                  mode
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_SORT,
		ST_MERGE
	} state_t;

	state_t state;
	logic [$clog2(NUM_SYM_P)-1:0] merge_cnt;
	logic load_en;
	logic last_merge;

	// Live node list, entry 0 is the lightest after a sort
	node_id_t node_id [NUM_SYM_P];
	weight_t  node_w  [NUM_SYM_P];
	node_id_t srt_id  [NUM_SYM_P];
	weight_t  srt_w   [NUM_SYM_P];

	// Weights are taken only while not busy
	assign load_en = in_valid && (state == ST_IDLE || state == ST_LOAD);
	assign last_merge = (merge_cnt == NUM_SYM_P - 2);

	// ======================================================================
	// FSM
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			merge_cnt <= '0;
			clear <= 1'b0;
			done <= 1'b0;
			mode <= 1'b0;
		end else begin
			clear <= 1'b0;
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (in_valid) begin
						state <= ST_LOAD;
						// Mode comes with the first weight
						mode <= out_mode;
						clear <= 1'b1;
						merge_cnt <= '0;
					end
				end
				ST_LOAD: begin
					if (!in_valid) begin
						state <= ST_SORT;
					end
				end
				ST_SORT: begin
					state <= ST_MERGE;
				end
				ST_MERGE: begin
					if (last_merge) begin
						state <= ST_IDLE;
						done <= 1'b1;
					end else begin
						state <= ST_SORT;
						merge_cnt <= merge_cnt + 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ======================================================================
	// Node list
	// ======================================================================
	always_ff @(posedge clk) begin
		if (load_en) begin
			// First weight ends up in entry 0 after the last shift
			for (int i = 0; i < NUM_SYM_P - 1; i++) begin
				node_w[i] <= node_w[i+1];
			end
			node_w[NUM_SYM_P-1] <= weight_t'(in_weight);
			if (state == ST_IDLE) begin
				for (int i = 0; i < NUM_SYM_P; i++) begin
					node_id[i] <= node_id_t'(i);
				end
			end
		end else if (state == ST_SORT) begin
			node_id <= srt_id;
			node_w <= srt_w;
		end else if (state == ST_MERGE) begin
			// Merged node takes slot 0, slot 1 goes empty
			node_id[0] <= mrg.new_node;
			node_w[0] <= node_w[0] + node_w[1];
			node_id[1] <= NODE_EMPTY;
			node_w[1] <= WEIGHT_EMPTY;
		end
	end

	ht_node_sorter #(
		.NUM_SYM_P(NUM_SYM_P)
	) u_sorter (
		.in_id (node_id),
		.in_w  (node_w),
		.out_id(srt_id),
		.out_w (srt_w)
	);

	// Two lightest entries of the registered sort result
	assign mrg.step = (state == ST_MERGE);
	assign mrg.small_node = node_id[0];
	assign mrg.big_node = node_id[1];
	assign mrg.new_node = node_id_t'(NUM_SYM_P) + node_id_t'(merge_cnt);

endmodule

// File: hw/ht_code_lane.sv
`timescale 1ns/100ps

module ht_code_lane import ht_pkg::*; #(
	parameter int SYM = 0
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  clear,
	merge_if.lane mrg,
	output code_t code,
	output len_t  len
);

	// Tree node that currently holds this symbol
	node_id_t grp;
	logic hit_small;
	logic hit_big;

	assign hit_small = (grp == mrg.small_node);
	assign hit_big = (grp == mrg.big_node);

	// ======================================================================
	// Group tracking and codeword build
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grp <= node_id_t'(SYM);
			code <= '0;
			len <= '0;
		end else if (clear) begin
			grp <= node_id_t'(SYM);
			code <= '0;
			len <= '0;
		end else if (mrg.step && (hit_small || hit_big)) begin
			// New bit is closer to the root than all earlier ones
			code <= {code[MAX_LEN-2:0], hit_small};
			len <= len + 1'b1;
			grp <= mrg.new_node;
		end
	end

endmodule

// File: hw/ht_code_serializer.sv
`timescale 1ns/100ps

module ht_code_serializer import ht_pkg::*; #(
	parameter int NUM_SYM_P = NUM_SYM
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  done,
	input  logic  mode,
	input  code_t code [NUM_SYM_P],
	input  len_t  len  [NUM_SYM_P],
	output logic  out_valid,
	output logic  out_code
);

	localparam int POS_W = $clog2(NUM_OUT);

	logic [POS_W-1:0] pos;
	logic [POS_W-1:0] load_pos;
	sym_t sel;
	// Bits still to send after the one on out_code
	len_t rem;
	code_t sh;
	logic word_end;
	logic last_pos;
	logic take;
	logic finish;

	assign word_end = out_valid && (rem == '0);
	assign last_pos = (pos == POS_W'(NUM_OUT - 1));
	assign take = done || (word_end && !last_pos);
	assign finish = word_end && last_pos;

	// Next sequence position, wrapped to stay in range
	assign load_pos = (done || last_pos) ? '0 : pos + 1'b1;
	assign sel = mode ? OUT_SEQ_1[load_pos] : OUT_SEQ_0[load_pos];

	// ======================================================================
	// Output stage
	// ======================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_code <= 1'b0;
			pos <= '0;
			rem <= '0;
		end else if (take) begin
			// First bit of the next word goes out at once
			out_valid <= 1'b1;
			out_code <= code[sel][0];
			rem <= len[sel] - 1'b1;
			pos <= load_pos;
		end else if (finish) begin
			out_valid <= 1'b0;
			out_code <= 1'b0;
			pos <= '0;
		end else if (out_valid) begin
			out_code <= sh[0];
			rem <= rem - 1'b1;
		end
	end

	// Remaining bits of the current word
	always_ff @(posedge clk) begin
		if (take) begin
			sh <= code[sel] >> 1;
		end else if (out_valid) begin
			sh <= sh >> 1;
		end
	end

endmodule

// File: hw/ht_top.sv
`timescale 1ns/100ps

module ht_top import ht_pkg::*; #(
	parameter int NUM_SYM_P = NUM_SYM
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic [IN_W_WIDTH-1:0] in_weight,
	input  logic                  out_mode,
	output logic                  out_valid,
	output logic                  out_code
);

	merge_if mrg ();

	logic clear;
	logic done;
	logic mode;
	code_t code [NUM_SYM_P];
	len_t  len  [NUM_SYM_P];

	ht_merge_ctrl #(
		.NUM_SYM_P(NUM_SYM_P)
	) u_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_weight(in_weight),
		.out_mode (out_mode),
		.mrg      (mrg),
		.clear    (clear),
		.done     (done),
		.mode     (mode)
	);

	// One lane per symbol
	for (genvar s = 0; s < NUM_SYM_P; s++) begin : g_lane
		ht_code_lane #(
			.SYM(s)
		) u_lane (
			.clk  (clk),
			.rst_n(rst_n),
			.clear(clear),
			.mrg  (mrg),
			.code (code[s]),
			.len  (len[s])
		);
	end

	ht_code_serializer #(
		.NUM_SYM_P(NUM_SYM_P)
	) u_ser (
		.clk      (clk),
		.rst_n    (rst_n),
		.done     (done),
		.mode     (mode),
		.code     (code),
		.len      (len),
		.out_valid(out_valid),
		.out_code (out_code)
	);

endmodule

// File: sim/ht_ref.svh
`ifndef HT_REF_SVH
`define HT_REF_SVH

// ======================================================================
// Reference Huffman model
// ======================================================================
// Bit len-1 of each value is the root side bit
int ref_code [NUM_SYM];
int ref_len [NUM_SYM];
logic exp_bits [$];

function automatic void build_ref_codes(input logic [3*NUM_SYM-1:0] wts);
	int nw [NUM_NODE];
	bit live [NUM_NODE];
	int grp [NUM_SYM];
	int lo;
	int hi;
	int new_id;

	for (int n = 0; n < NUM_NODE; n++) begin
		nw[n] = 0;
		live[n] = (n < NUM_SYM);
	end
	for (int s = 0; s < NUM_SYM; s++) begin
		nw[s] = wts[(NUM_SYM-1-s)*IN_W_WIDTH +: IN_W_WIDTH];
		grp[s] = s;
		ref_code[s] = 0;
		ref_len[s] = 0;
	end
	for (int k = 0; k < NUM_SYM - 1; k++) begin
		lo = -1;
		hi = -1;
		new_id = NUM_SYM + k;
		// Ids scanned upward, so a tie keeps the lower id in front
		for (int n = 0; n < new_id; n++) begin
			if (live[n]) begin
				if (lo < 0 || nw[n] < nw[lo]) begin
					hi = lo;
					lo = n;
				end else if (hi < 0 || nw[n] < nw[hi]) begin
					hi = n;
				end
			end
		end
		nw[new_id] = nw[lo] + nw[hi];
		live[new_id] = 1'b1;
		live[lo] = 1'b0;
		live[hi] = 1'b0;
		for (int s = 0; s < NUM_SYM; s++) begin
			if (grp[s] == lo || grp[s] == hi) begin
				// Smaller side of the merge gets a 1
				if (grp[s] == lo) begin
					ref_code[s] = ref_code[s] | (1 << ref_len[s]);
				end
				ref_len[s]++;
				grp[s] = new_id;
			end
		end
	end
endfunction

// Root side bit of each word first
function automatic void expected_stream(input logic mode);
	int s;

	exp_bits.delete();
	for (int p = 0; p < NUM_OUT; p++) begin
		s = mode ? OUT_SEQ_1[p] : OUT_SEQ_0[p];
		for (int b = ref_len[s] - 1; b >= 0; b--) begin
			exp_bits.push_back(ref_code[s][b]);
		end
	end
endfunction

`endif

// File: sim/ht_tb.sv
`timescale 1ns/100ps

module ht_tb import ht_pkg::*; ();

	localparam int NUM_FIXED = 6;
	localparam int NUM_RAND = 12;
	localparam int TIMEOUT = 200;
	// Edges from the first idle in_valid cycle to the first output bit
	localparam int FIRST_OUT = 16;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [IN_W_WIDTH-1:0] in_weight;
	logic out_mode;
	logic out_valid;
	logic out_code;
	logic got_bits [$];
	int case_no;

	// Weights in octal with symbol 0 as the leftmost digit
	logic [3*NUM_SYM-1:0] tbl_w [NUM_FIXED] = '{
		24'o44444444, 24'o77777777, 24'o11235777, 24'o11235777, 24'o00011235, 24'o00011235
	};
	logic tbl_mode [NUM_FIXED] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
	// Hand computed sum of the five codeword lengths
	int tbl_total [NUM_FIXED] = '{15, 15, 20, 14, 29, 17};

	`include "ht_ref.svh"

	ht_top #(
		.NUM_SYM_P(NUM_SYM)
	) dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_weight(in_weight),
		.out_mode (out_mode),
		.out_valid(out_valid),
		.out_code (out_code)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: case %0d, %s, got %0d expected %0d",
				$time, case_no, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "wrong value from the DUT");
		end
	endtask

	task automatic timeout_abort(input string what);
		$display("Case %0d gave up waiting: %s", case_no, what);
		$display("STATUS: FAIL");
		$fatal(1, "wait loop ran out of cycles");
	endtask

	// ======================================================================
	// One run loads the weights, then collects and compares the bitstream
	// ======================================================================
	task automatic run_case(input logic [3*NUM_SYM-1:0] wts, input logic mode,
		input int exp_total);
		int cnt;

		build_ref_codes(wts);
		expected_stream(mode);
		@(posedge clk);
		#2;
		for (int i = 0; i < NUM_SYM; i++) begin
			in_valid = 1'b1;
			in_weight = wts[(NUM_SYM-1-i)*IN_W_WIDTH +: IN_W_WIDTH];
			// Only the first weight cycle carries the mode
			out_mode = (i == 0) ? mode : ~mode;
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
		in_weight = '0;
		out_mode = 1'b0;

		cnt = 0;
		while (out_valid !== 1'b1) begin
			if (cnt == TIMEOUT) begin
				timeout_abort("out_valid never rose after the weights");
			end
			@(posedge clk);
			@(negedge clk);
			cnt++;
			if (out_valid !== 1'b1) begin
				check_eq(out_code, 1'b0, "out_code while out_valid is low");
			end
		end
		check_eq(cnt, FIRST_OUT, "cycles to first output bit");

		got_bits.delete();
		cnt = 0;
		while (out_valid === 1'b1) begin
			if (cnt == TIMEOUT) begin
				timeout_abort("out_valid did not fall");
			end
			got_bits.push_back(out_code);
			@(negedge clk);
			cnt++;
		end
		check_eq(out_code, 1'b0, "out_code after out_valid fell");
		check_eq(got_bits.size(), exp_bits.size(), "bitstream length");
		if (exp_total >= 0) begin
			check_eq(got_bits.size(), exp_total, "bitstream length from table");
		end
		for (int k = 0; k < exp_bits.size(); k++) begin
			check_eq(got_bits[k], exp_bits[k], $sformatf("stream bit %0d", k));
		end
	endtask

	initial begin
		logic [3*NUM_SYM-1:0] rnd_w;
		logic rnd_mode;

		rst_n = 1'b0;
		in_valid = 1'b0;
		in_weight = '0;
		out_mode = 1'b0;
		case_no = 0;
		void'($urandom(32'hdbaf));
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_eq(out_valid, 1'b0, "out_valid after reset");
		check_eq(out_code, 1'b0, "out_code after reset");

		for (int c = 0; c < NUM_FIXED; c++) begin
			case_no = c;
			run_case(tbl_w[c], tbl_mode[c], tbl_total[c]);
		end
		// Back to back random runs without a reset in between
		for (int c = 0; c < NUM_RAND; c++) begin
			case_no = NUM_FIXED + c;
			for (int i = 0; i < NUM_SYM; i++) begin
				rnd_w[i*IN_W_WIDTH +: IN_W_WIDTH] = $urandom_range(7, 0);
			end
			rnd_mode = $urandom_range(1, 0);
			run_case(rnd_w, rnd_mode, -1);
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: ht_top.f
+incdir+sim
hw/ht_pkg.sv
hw/ht_merge_if.sv
hw/ht_node_sorter.sv
hw/ht_merge_ctrl.sv
hw/ht_code_lane.sv
hw/ht_code_serializer.sv
hw/ht_top.sv
sim/ht_tb.sv
